// File: Makefile
# Verilator build and run for the power2round testbench

VERILATOR ?= verilator
TOP       ?= tb_p2r_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: hw/p2r_apb_regs.sv
`timescale 1ns/100ps

module p2r_apb_regs (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  p2r_pkg::apb_addr_t  paddr,
    input  p2r_pkg::apb_data_t  pwdata,
    output p2r_pkg::apb_data_t  prdata,
    output logic                pready,
    output logic                pslverr,
    input  logic                busy,
    input  logic                finish,
    output logic                start,
    output logic                zeroize,
    output p2r_pkg::addr_t      src_base,
    output p2r_pkg::addr_t      sk_base
);

    logic access;
    logic wr_access;
    logic mapped;
    logic done;

    // no wait states
    assign pready = 1'b1;

    assign access    = psel && penable;
    assign wr_access = access && pwrite;

    assign mapped = (paddr == p2r_pkg::REG_CTRL) || (paddr == p2r_pkg::REG_STATUS) ||
                    (paddr == p2r_pkg::REG_SRC_BASE) || (paddr == p2r_pkg::REG_SK_BASE);

    assign pslverr = access && !mapped;

    // ----------------------------------------
    // control pulses
    // ----------------------------------------
    assign start   = wr_access && (paddr == p2r_pkg::REG_CTRL) &&
                     pwdata[p2r_pkg::CTRL_START_BIT];
    assign zeroize = wr_access && (paddr == p2r_pkg::REG_CTRL) &&
                     pwdata[p2r_pkg::CTRL_ZEROIZE_BIT];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            src_base <= '0;
            sk_base  <= '0;
            done     <= 1'b0;
        end else if (zeroize) begin
            src_base <= '0;
            sk_base  <= '0;
            done     <= 1'b0;
        end else begin
            if (wr_access && (paddr == p2r_pkg::REG_SRC_BASE)) begin
                src_base <= p2r_pkg::addr_t'(pwdata);
            end
            if (wr_access && (paddr == p2r_pkg::REG_SK_BASE)) begin
                sk_base <= p2r_pkg::addr_t'(pwdata);
            end
            // sticky until the next accepted start
            if (finish) begin
                done <= 1'b1;
            end else if (start && !busy) begin
                done <= 1'b0;
            end
        end
    end

    // read mux
    always_comb begin
        prdata = '0;
        case (paddr)
            p2r_pkg::REG_STATUS: begin
                prdata[p2r_pkg::STATUS_BUSY_BIT] = busy;
                prdata[p2r_pkg::STATUS_DONE_BIT] = done;
            end
            p2r_pkg::REG_SRC_BASE: prdata = p2r_pkg::apb_data_t'(src_base);
            p2r_pkg::REG_SK_BASE:  prdata = p2r_pkg::apb_data_t'(sk_base);
            default:               prdata = '0;
        endcase
    end

endmodule

// File: hw/p2r_ctrl.sv
`timescale 1ns/100ps

module p2r_ctrl #(
    parameter int DILITHIUM_K = 2,
    parameter int DILITHIUM_N = 16
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            start,
    input  logic            zeroize,
    input  p2r_pkg::addr_t  src_base,
    input  p2r_pkg::addr_t  sk_base,
    input  logic            stall,
    output logic            src_rd_en,
    output p2r_pkg::addr_t  src_a_addr,
    output p2r_pkg::addr_t  src_b_addr,
    output logic            lane_valid,
    output p2r_pkg::addr_t  sk_wr_addr,
    output logic            last_pair,
    input  logic            pk_done,
    output logic            busy,
    output logic            finish
);

    localparam int NUM_PAIRS = DILITHIUM_K * DILITHIUM_N / 2;
    // offset of the last pair from src_base
    localparam p2r_pkg::addr_t LAST_OFS = p2r_pkg::addr_t'(2 * (NUM_PAIRS - 1));

    p2r_pkg::rd_state_t state, state_nxt;

    p2r_pkg::addr_t rd_addr;
    p2r_pkg::addr_t rd_addr_dly;
    p2r_pkg::addr_t issue_addr;
    p2r_pkg::addr_t sk_addr;
    logic           last_rd;
    logic           issue_last;
    logic           rd_en_q;
    logic           last_q1;
    logic           valid_q2;
    logic           last_q2;

    assign last_rd    = (rd_addr == src_base + LAST_OFS);
    assign issue_last = (issue_addr == src_base + LAST_OFS);

    // ----------------------------------------
    // read FSM
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        finish    = 1'b0;
        case (state)
            p2r_pkg::RD_IDLE: begin
                if (start) begin
                    state_nxt = p2r_pkg::RD_RUN;
                end
            end
            p2r_pkg::RD_RUN: begin
                if (!stall && last_rd) begin
                    state_nxt = p2r_pkg::RD_DRAIN;
                end
            end
            p2r_pkg::RD_DRAIN: begin
                // last pk word has gone out
                if (pk_done) begin
                    state_nxt = p2r_pkg::RD_IDLE;
                    finish    = 1'b1;
                end
            end
            default: state_nxt = p2r_pkg::RD_IDLE;
        endcase
    end

    assign busy = (state != p2r_pkg::RD_IDLE);

    // a stalled cycle repeats the previous issue so memory data lines up again
    assign src_rd_en  = (state == p2r_pkg::RD_RUN) || (stall && rd_en_q);
    assign issue_addr = stall ? rd_addr_dly : rd_addr;
    assign src_a_addr = issue_addr;
    assign src_b_addr = issue_addr + p2r_pkg::addr_t'(1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= p2r_pkg::RD_IDLE;
            rd_addr     <= '0;
            rd_addr_dly <= '0;
            sk_addr     <= '0;
            rd_en_q     <= 1'b0;
            last_q1     <= 1'b0;
            valid_q2    <= 1'b0;
            last_q2     <= 1'b0;
        end else if (zeroize) begin
            state       <= p2r_pkg::RD_IDLE;
            rd_addr     <= '0;
            rd_addr_dly <= '0;
            sk_addr     <= '0;
            rd_en_q     <= 1'b0;
            last_q1     <= 1'b0;
            valid_q2    <= 1'b0;
            last_q2     <= 1'b0;
        end else begin
            state       <= state_nxt;
            rd_addr_dly <= issue_addr;

            if ((state == p2r_pkg::RD_IDLE) && start) begin
                rd_addr <= src_base;
                sk_addr <= sk_base;
            end else begin
                if ((state == p2r_pkg::RD_RUN) && !stall && !last_rd) begin
                    rd_addr <= rd_addr + p2r_pkg::addr_t'(2);
                end
                if (valid_q2 && !stall) begin
                    sk_addr <= sk_addr + p2r_pkg::addr_t'(1);
                end
            end

            // memory stage
            rd_en_q <= src_rd_en;
            last_q1 <= src_rd_en && issue_last;

            // lane stage, frozen like the lane registers
            if (!stall) begin
                valid_q2 <= rd_en_q;
                last_q2  <= last_q1;
            end
        end
    end

    assign lane_valid = rd_en_q;
    assign last_pair  = last_q2;
    assign sk_wr_addr = sk_addr;

    a_rd_addr_in_range: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        src_rd_en |-> (p2r_pkg::addr_t'(issue_addr - src_base) <= LAST_OFS));

endmodule

// File: hw/p2r_exec.sv
`timescale 1ns/100ps

module p2r_exec (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             zeroize,
    input  logic             in_valid,
    input  logic             stall,
    input  p2r_pkg::coeff_t  coeff,
    output logic             out_valid,
    output p2r_pkg::t1_t     t1,
    output p2r_pkg::t0_t     t0
);

    // 2^(d-1) and its predecessor
    localparam p2r_pkg::coeff_t HALF    = p2r_pkg::coeff_t'(1) << (p2r_pkg::P2R_D - 1);
    localparam p2r_pkg::coeff_t HALF_M1 = HALF - p2r_pkg::coeff_t'(1);

    logic [p2r_pkg::COEFF_W:0] rounded;
    p2r_pkg::coeff_t           low_diff;
    p2r_pkg::t1_t              t1_nxt;
    p2r_pkg::t0_t              t0_nxt;

    // t1 = (r + 2^(d-1) - 1) >> d, t0 = 2^(d-1) - (r - t1 * 2^d)
    always_comb begin
        rounded  = {1'b0, coeff} + {1'b0, HALF_M1};
        t1_nxt   = p2r_pkg::t1_t'(rounded >> p2r_pkg::P2R_D);
        low_diff = coeff - (p2r_pkg::coeff_t'(t1_nxt) << p2r_pkg::P2R_D);
        t0_nxt   = p2r_pkg::t0_t'(HALF - low_diff);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else if (zeroize) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    // t0 is secret material, cleared on zeroize
    always_ff @(posedge clk) begin
        if (zeroize) begin
            t1 <= '0;
            t0 <= '0;
        end else if (in_valid && !stall) begin
            t1 <= t1_nxt;
            t0 <= t0_nxt;
        end
    end

    a_coeff_below_q: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        (in_valid && !stall) |-> (coeff < p2r_pkg::P2R_Q));

endmodule

// File: hw/p2r_pkg.sv
package p2r_pkg;

    // ----------------------------------------
    // field widths
    // ----------------------------------------
    localparam int COEFF_W = 24;
    localparam int T1_W    = 10;
    localparam int T0_W    = 13;
    localparam int ADDR_W  = 16;

    typedef logic [COEFF_W-1:0] coeff_t;
    typedef logic [T1_W-1:0]    t1_t;
    typedef logic [T0_W-1:0]    t0_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    // lane b in the upper half
    typedef logic [2*T0_W-1:0]  sk_word_t;
    // oldest t1 in the lowest bits
    typedef logic [4*T1_W-1:0]  pk_word_t;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // power2round constants
    localparam int     P2R_D = 13;
    localparam coeff_t P2R_Q = 24'd8380417;

    // ----------------------------------------
    // register map
    // ----------------------------------------
    localparam apb_addr_t REG_CTRL     = 8'h00;
    localparam apb_addr_t REG_STATUS   = 8'h04;
    localparam apb_addr_t REG_SRC_BASE = 8'h08;
    localparam apb_addr_t REG_SK_BASE  = 8'h0C;

    localparam int CTRL_START_BIT   = 0;
    localparam int CTRL_ZEROIZE_BIT = 1;
    localparam int STATUS_BUSY_BIT  = 0;
    localparam int STATUS_DONE_BIT  = 1;

    // state machines
    typedef enum logic [1:0] {RD_IDLE, RD_RUN, RD_DRAIN} rd_state_t;
    typedef enum logic [1:0] {PK_EMPTY, PK_HALF, PK_HOLD} pk_state_t;

endpackage

// File: hw/p2r_result.sv
`timescale 1ns/100ps

module p2r_result (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize,
    input  logic                pair_valid,
    input  logic                last_pair,
    input  p2r_pkg::addr_t      sk_addr,
    input  p2r_pkg::t1_t        t1_a,
    input  p2r_pkg::t1_t        t1_b,
    input  p2r_pkg::t0_t        t0_a,
    input  p2r_pkg::t0_t        t0_b,
    input  logic                pk_ready,
    output logic                sk_wr_en,
    output p2r_pkg::addr_t      sk_wr_addr,
    output p2r_pkg::sk_word_t   sk_wr_data,
    output logic                pk_wr_en,
    output p2r_pkg::addr_t      pk_wr_addr,
    output p2r_pkg::pk_word_t   pk_wr_data,
    output logic                stall,
    output logic                pk_done
);

    p2r_pkg::pk_state_t state;

    logic [2*p2r_pkg::T1_W-1:0] pk_lo;
    p2r_pkg::pk_word_t          pk_word;
    p2r_pkg::addr_t             pk_idx;
    logic                       pk_last;
    logic                       take;
    logic                       transfer;

    // ----------------------------------------
    // sk words
    // ----------------------------------------
    assign sk_wr_en   = pair_valid && !stall;
    assign sk_wr_addr = sk_addr;
    assign sk_wr_data = {t0_b, t0_a};

    // ----------------------------------------
    // pk packing
    // ----------------------------------------
    assign pk_wr_en   = (state == p2r_pkg::PK_HOLD);
    assign pk_wr_data = pk_word;
    assign pk_wr_addr = pk_idx;
    assign stall      = pk_wr_en && !pk_ready;
    assign take       = pair_valid && !stall;
    assign transfer   = pk_wr_en && pk_ready;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= p2r_pkg::PK_EMPTY;
            pk_idx  <= '0;
            pk_last <= 1'b0;
            pk_done <= 1'b0;
        end else if (zeroize) begin
            state   <= p2r_pkg::PK_EMPTY;
            pk_idx  <= '0;
            pk_last <= 1'b0;
            pk_done <= 1'b0;
        end else begin
            pk_done <= transfer && pk_last;
            // index restarts after the final word of a run
            if (transfer) begin
                pk_idx <= pk_last ? '0 : pk_idx + p2r_pkg::addr_t'(1);
            end
            case (state)
                p2r_pkg::PK_EMPTY: begin
                    if (take) begin
                        state <= p2r_pkg::PK_HALF;
                    end
                end
                p2r_pkg::PK_HALF: begin
                    if (take) begin
                        state   <= p2r_pkg::PK_HOLD;
                        pk_last <= last_pair;
                    end
                end
                p2r_pkg::PK_HOLD: begin
                    if (transfer) begin
                        state <= take ? p2r_pkg::PK_HALF : p2r_pkg::PK_EMPTY;
                    end
                end
                default: state <= p2r_pkg::PK_EMPTY;
            endcase
        end
    end

    // first pair waits in pk_lo, second completes the word
    always_ff @(posedge clk) begin
        if (take) begin
            if (state == p2r_pkg::PK_HALF) begin
                pk_word <= {t1_b, t1_a, pk_lo};
            end else begin
                pk_lo <= {t1_b, t1_a};
            end
        end
    end

    a_pk_data_stable: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        (pk_wr_en && !pk_ready) |=> (pk_wr_en && $stable(pk_wr_data)));

endmodule

// File: hw/p2r_top.sv
`timescale 1ns/100ps

module p2r_top #(
    parameter int DILITHIUM_K = 2,
    parameter int DILITHIUM_N = 16
) (
    input  logic                clk,
    input  logic                reset_n,
    // APB slave
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  p2r_pkg::apb_addr_t  paddr,
    input  p2r_pkg::apb_data_t  pwdata,
    output p2r_pkg::apb_data_t  prdata,
    output logic                pready,
    output logic                pslverr,
    // source memory
    output logic                src_rd_en,
    output p2r_pkg::addr_t      src_a_addr,
    output p2r_pkg::addr_t      src_b_addr,
    input  p2r_pkg::coeff_t     src_a_data,
    input  p2r_pkg::coeff_t     src_b_data,
    // secret-key memory
    output logic                sk_wr_en,
    output p2r_pkg::addr_t      sk_wr_addr,
    output p2r_pkg::sk_word_t   sk_wr_data,
    // public-key port
    output logic                pk_wr_en,
    output p2r_pkg::addr_t      pk_wr_addr,
    output p2r_pkg::pk_word_t   pk_wr_data,
    input  logic                pk_ready
);

    logic            start;
    logic            zeroize;
    logic            busy;
    logic            finish;
    p2r_pkg::addr_t  src_base;
    p2r_pkg::addr_t  sk_base;
    logic            stall;
    logic            lane_valid;
    p2r_pkg::addr_t  sk_addr;
    logic            last_pair;
    logic            pk_done;
    logic            pair_valid;
    p2r_pkg::t1_t    t1_a;
    p2r_pkg::t1_t    t1_b;
    p2r_pkg::t0_t    t0_a;
    p2r_pkg::t0_t    t0_b;

    p2r_apb_regs i_apb_regs (
        .clk      (clk),
        .reset_n  (reset_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .busy     (busy),
        .finish   (finish),
        .start    (start),
        .zeroize  (zeroize),
        .src_base (src_base),
        .sk_base  (sk_base)
    );

    p2r_ctrl #(
        .DILITHIUM_K (DILITHIUM_K),
        .DILITHIUM_N (DILITHIUM_N)
    ) i_ctrl (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (start),
        .zeroize    (zeroize),
        .src_base   (src_base),
        .sk_base    (sk_base),
        .stall      (stall),
        .src_rd_en  (src_rd_en),
        .src_a_addr (src_a_addr),
        .src_b_addr (src_b_addr),
        .lane_valid (lane_valid),
        .sk_wr_addr (sk_addr),
        .last_pair  (last_pair),
        .pk_done    (pk_done),
        .busy       (busy),
        .finish     (finish)
    );

    // ----------------------------------------
    // execute lanes
    // ----------------------------------------
    p2r_exec lane_a (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_valid  (lane_valid),
        .stall     (stall),
        .coeff     (src_a_data),
        .out_valid (pair_valid),
        .t1        (t1_a),
        .t0        (t0_a)
    );

    // lanes run in lockstep so lane a's valid covers both
    p2r_exec lane_b (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_valid  (lane_valid),
        .stall     (stall),
        .coeff     (src_b_data),
        .out_valid (),
        .t1        (t1_b),
        .t0        (t0_b)
    );

    p2r_result i_result (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .pair_valid (pair_valid),
        .last_pair  (last_pair),
        .sk_addr    (sk_addr),
        .t1_a       (t1_a),
        .t1_b       (t1_b),
        .t0_a       (t0_a),
        .t0_b       (t0_b),
        .pk_ready   (pk_ready),
        .sk_wr_en   (sk_wr_en),
        .sk_wr_addr (sk_wr_addr),
        .sk_wr_data (sk_wr_data),
        .pk_wr_en   (pk_wr_en),
        .pk_wr_addr (pk_wr_addr),
        .pk_wr_data (pk_wr_data),
        .stall      (stall),
        .pk_done    (pk_done)
    );

endmodule

// File: testbench/tb_p2r_top.sv
`timescale 1ns/100ps

module tb_p2r_top;

    localparam int K        = 2;
    localparam int N        = 16;
    localparam int PAIRS    = K * N / 2;
    localparam int PK_WORDS = PAIRS / 2;
    localparam int MEM_SIZE = 256;
    localparam int TIMEOUT  = 500;
    localparam int Q        = 8380417;

    logic                clk = 1'b0;
    logic                reset_n = 1'b0;
    logic                psel = 1'b0;
    logic                penable = 1'b0;
    logic                pwrite = 1'b0;
    p2r_pkg::apb_addr_t  paddr = '0;
    p2r_pkg::apb_data_t  pwdata = '0;
    p2r_pkg::apb_data_t  prdata;
    logic                pready;
    logic                pslverr;
    logic                src_rd_en;
    p2r_pkg::addr_t      src_a_addr;
    p2r_pkg::addr_t      src_b_addr;
    p2r_pkg::coeff_t     src_a_data = '0;
    p2r_pkg::coeff_t     src_b_data = '0;
    logic                sk_wr_en;
    p2r_pkg::addr_t      sk_wr_addr;
    p2r_pkg::sk_word_t   sk_wr_data;
    logic                pk_wr_en;
    p2r_pkg::addr_t      pk_wr_addr;
    p2r_pkg::pk_word_t   pk_wr_data;
    logic                pk_ready = 1'b1;

    // memory models and write capture
    p2r_pkg::coeff_t   src_mem [MEM_SIZE];
    p2r_pkg::sk_word_t sk_mem [MEM_SIZE];
    int                sk_cnt [MEM_SIZE] = '{default: 0};
    p2r_pkg::pk_word_t pk_mem [PK_WORDS];
    int                pk_cnt [PK_WORDS] = '{default: 0};
    int                sk_total = 0;
    int                pk_total = 0;
    int                pk_wait_cycles = 0;

    // counters at the start of the current run
    int                sk_total_0;
    int                pk_total_0;
    int                pk_cnt_0 [PK_WORDS];

    logic [31:0]       lfsr_state = 32'd60;
    logic              bp_mode = 1'b0;
    logic              pk_waiting = 1'b0;
    p2r_pkg::pk_word_t pk_held = '0;
    int                errors = 0;
    int                checks = 0;

    always #4 clk = ~clk;

    p2r_top #(
        .DILITHIUM_K (K),
        .DILITHIUM_N (N)
    ) i_p2r_top (
        .clk        (clk),
        .reset_n    (reset_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .src_rd_en  (src_rd_en),
        .src_a_addr (src_a_addr),
        .src_b_addr (src_b_addr),
        .src_a_data (src_a_data),
        .src_b_data (src_b_data),
        .sk_wr_en   (sk_wr_en),
        .sk_wr_addr (sk_wr_addr),
        .sk_wr_data (sk_wr_data),
        .pk_wr_en   (pk_wr_en),
        .pk_wr_addr (pk_wr_addr),
        .pk_wr_data (pk_wr_data),
        .pk_ready   (pk_ready)
    );

    // ----------------------------------------
    // random bits and reference model
    // ----------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one step per bit and the first bit ends up in the msb
    function automatic int rand_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic int high_part(input int r);
        return (r + 4095) >> 13;
    endfunction

    // 4096 minus the remainder kept to 13 bits
    function automatic int low_part(input int r);
        int diff;
        diff = r - (high_part(r) << 13);
        return (4096 - diff) & 32'h1FFF;
    endfunction

    function automatic logic [63:0] sk_word_model(input int src, input int pair);
        int a;
        int b;
        a = int'(src_mem[src + 2 * pair]);
        b = int'(src_mem[src + 2 * pair + 1]);
        return 64'((low_part(b) << 13) | low_part(a));
    endfunction

    function automatic logic [63:0] pk_word_model(input int src, input int word);
        logic [63:0] w;
        w = '0;
        for (int i = 3; i >= 0; i--) begin
            w = (w << 10) | 64'(high_part(int'(src_mem[src + 4 * word + i])));
        end
        return w;
    endfunction

    function automatic p2r_pkg::coeff_t read_src(input p2r_pkg::addr_t a);
        if (a < 16'(MEM_SIZE)) begin
            return src_mem[a[7:0]];
        end else begin
            return '0;
        end
    endfunction

    // ----------------------------------------
    // reporting
    // ----------------------------------------
    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s at %0t", msg, $time);
    endtask

    task automatic finish_run();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    // ----------------------------------------
    // memory models
    // ----------------------------------------
    always @(posedge clk) begin
        if (src_rd_en) begin
            src_a_data <= read_src(src_a_addr);
            src_b_data <= read_src(src_b_addr);
        end
    end

    always @(posedge clk) begin
        if (bp_mode) begin
            pk_ready <= 1'(rand_bits(1));
        end else begin
            pk_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (sk_wr_en) begin
            if (sk_wr_addr < 16'(MEM_SIZE)) begin
                sk_mem[sk_wr_addr[7:0]] <= sk_wr_data;
                sk_cnt[sk_wr_addr[7:0]] <= sk_cnt[sk_wr_addr[7:0]] + 1;
            end else begin
                report_failure("sk write outside the modelled memory");
            end
            sk_total <= sk_total + 1;
        end
        if (pk_wr_en && pk_ready) begin
            if (pk_wr_addr < 16'(PK_WORDS)) begin
                pk_mem[pk_wr_addr[2:0]] <= pk_wr_data;
                pk_cnt[pk_wr_addr[2:0]] <= pk_cnt[pk_wr_addr[2:0]] + 1;
            end else begin
                report_failure("pk write to an index past the last word");
            end
            pk_total <= pk_total + 1;
        end
        // a waiting word must stay put
        if (pk_waiting) begin
            check_value("pk_wr_en", 64'(pk_wr_en), 64'd1);
            check_value("pk_wr_data", 64'(pk_wr_data), 64'(pk_held));
        end
        if (pk_wr_en && !pk_ready) begin
            pk_wait_cycles <= pk_wait_cycles + 1;
        end
        pk_waiting <= reset_n && pk_wr_en && !pk_ready;
        pk_held    <= pk_wr_data;
    end

    // ----------------------------------------
    // APB and run control
    // ----------------------------------------
    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (pready !== 1'b1) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("timed out waiting for pready");
                return;
            end
            @(posedge clk);
        end
    endtask

    task automatic apb_write(input p2r_pkg::apb_addr_t addr, input p2r_pkg::apb_data_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        wait_ready();
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input p2r_pkg::apb_addr_t addr, output p2r_pkg::apb_data_t data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        wait_ready();
        data    = prdata;
        err     = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic start_run(input int src, input int sk);
        sk_total_0 = sk_total;
        pk_total_0 = pk_total;
        for (int w = 0; w < PK_WORDS; w++) begin
            pk_cnt_0[w] = pk_cnt[w];
        end
        apb_write(p2r_pkg::REG_SRC_BASE, 32'(src));
        apb_write(p2r_pkg::REG_SK_BASE, 32'(sk));
        apb_write(p2r_pkg::REG_CTRL, 32'h1);
    endtask

    task automatic wait_done();
        p2r_pkg::apb_data_t status;
        logic               err;
        int                 polls;
        polls = 0;
        apb_read(p2r_pkg::REG_STATUS, status, err);
        while (status[p2r_pkg::STATUS_DONE_BIT] !== 1'b1) begin
            polls++;
            if (polls > TIMEOUT) begin
                report_failure("timed out waiting for done");
                return;
            end
            apb_read(p2r_pkg::REG_STATUS, status, err);
        end
        // done set and busy clear
        check_value("status", 64'(status), 64'h2);
    endtask

    task automatic wait_sk_writes(input int count);
        int cycles;
        cycles = 0;
        while (sk_total - sk_total_0 < count) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("timed out waiting for sk writes");
                return;
            end
            @(posedge clk);
        end
    endtask

    task automatic check_run(input int src, input int sk);
        check_value("sk write total", 64'(sk_total - sk_total_0), 64'(PAIRS));
        check_value("pk write total", 64'(pk_total - pk_total_0), 64'(PK_WORDS));
        for (int i = 0; i < PAIRS; i++) begin
            check_value($sformatf("sk write count[%0d]", sk + i), 64'(sk_cnt[sk + i]), 64'd1);
            check_value($sformatf("sk_wr_data[%0d]", sk + i), 64'(sk_mem[sk + i]),
                        sk_word_model(src, i));
        end
        for (int w = 0; w < PK_WORDS; w++) begin
            check_value($sformatf("pk write count[%0d]", w), 64'(pk_cnt[w] - pk_cnt_0[w]),
                        64'd1);
            check_value($sformatf("pk_wr_data[%0d]", w), 64'(pk_mem[w]), pk_word_model(src, w));
        end
    endtask

    // random fill with fixed corner values every 16 words
    task automatic fill_source();
        int v;
        for (int a = 0; a < MEM_SIZE; a++) begin
            v = rand_bits(23);
            if (v >= Q) begin
                v = v - Q;
            end
            case (a % 16)
                0: v = 0;
                5: v = Q - 1;
                9: v = (a / 16) * 8192;
                default: v = v;
            endcase
            src_mem[a] = p2r_pkg::coeff_t'(v);
        end
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic register_access();
        p2r_pkg::apb_data_t data;
        logic               err;
        apb_read(p2r_pkg::REG_STATUS, data, err);
        check_value("status after reset", 64'(data), 64'h0);
        check_value("pslverr", 64'(err), 64'h0);
        apb_write(p2r_pkg::REG_SRC_BASE, 32'h1234);
        apb_write(p2r_pkg::REG_SK_BASE, 32'hABCD);
        apb_read(p2r_pkg::REG_SRC_BASE, data, err);
        check_value("src_base", 64'(data), 64'h1234);
        apb_read(p2r_pkg::REG_SK_BASE, data, err);
        check_value("sk_base", 64'(data), 64'hABCD);
        apb_read(8'h10, data, err);
        check_value("pslverr unmapped", 64'(err), 64'h1);
    endtask

    task automatic full_run();
        start_run('h00, 'h20);
        wait_done();
        check_run('h00, 'h20);
    endtask

    task automatic backpressure_run();
        int waits_0;
        waits_0 = pk_wait_cycles;
        @(posedge clk);
        bp_mode <= 1'b1;
        start_run('h00, 'h40);
        wait_done();
        bp_mode <= 1'b0;
        check_run('h00, 'h40);
        if (pk_wait_cycles == waits_0) begin
            report_failure("pk_ready never held a word back");
        end
    endtask

    task automatic boundary_coeffs();
        src_mem[8'h80] = '0;
        src_mem[8'h81] = p2r_pkg::coeff_t'(Q - 1);
        src_mem[8'h82] = 24'd4095;
        src_mem[8'h83] = 24'd4096;
        src_mem[8'h84] = 24'd8191;
        start_run('h80, 'h60);
        wait_done();
        check_run('h80, 'h60);
    endtask

    task automatic zeroize_restart();
        p2r_pkg::apb_data_t status;
        logic               err;
        int                 sk_seen;
        int                 pk_seen;
        start_run('h20, 'h00);
        wait_sk_writes(4);
        apb_write(p2r_pkg::REG_CTRL, 32'h2);
        @(posedge clk);
        sk_seen = sk_total;
        pk_seen = pk_total;
        apb_read(p2r_pkg::REG_STATUS, status, err);
        check_value("status after zeroize", 64'(status), 64'h0);
        repeat (40) @(posedge clk);
        check_value("sk writes after zeroize", 64'(sk_total - sk_seen), 64'd0);
        check_value("pk writes after zeroize", 64'(pk_total - pk_seen), 64'd0);
        start_run('h40, 'h90);
        wait_done();
        check_run('h40, 'h90);
    endtask

    task automatic start_while_busy();
        start_run('hA0, 'hC0);
        wait_sk_writes(3);
        apb_write(p2r_pkg::REG_CTRL, 32'h1);
        wait_done();
        check_run('hA0, 'hC0);
    endtask

    initial begin
        fill_source();
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        register_access();
        full_run();
        backpressure_run();
        boundary_coeffs();
        zeroize_restart();
        start_while_busy();
        repeat (4) @(posedge clk);
        finish_run();
    end

endmodule

// File: verilog.f
hw/p2r_pkg.sv
hw/p2r_apb_regs.sv
hw/p2r_ctrl.sv
hw/p2r_exec.sv
hw/p2r_result.sv
hw/p2r_top.sv
testbench/tb_p2r_top.sv
